//--- bench/cpuCoreTb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench of the single-cycle WISC core
// Instruction and data memories, random and directed programs,
// instruction-set model stepped once per cycle, watchdog and report
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cpuCoreTb;

	localparam int randLen = 248;
	localparam int dirLen = 9;
	localparam int clkPeriod = 100;
	localparam int watchdogNs = (randLen + dirLen + 20) * clkPeriod;
	localparam logic [15:0] nopWord = 16'h0800;
	localparam logic [15:0] haltWord = 16'h0000;

	logic clk;
	logic reset;
	logic [15:0] instrAddr, instr;
	logic [15:0] dataAddr, dataWrData, dataRdData;
	logic dataRead, dataWrite, halt, err;

	// Program and data memories, model state
	logic [15:0] imem [256];
	logic [15:0] dmem [256];
	logic [15:0] mdmem [256];
	logic [15:0] mregs [8];
	logic [15:0] mpc;
	logic haltSeen;
	logic dataInit = 1'b0;
	integer seed;
	int errorCount, checkCount, progIdx;
	string testName;

	cpuCore #(.resetPc(16'h0000)) dut_i (
		.clk(clk),
		.reset(reset),
		.instrAddr(instrAddr),
		.instr(instr),
		.dataAddr(dataAddr),
		.dataWrData(dataWrData),
		.dataRdData(dataRdData),
		.dataRead(dataRead),
		.dataWrite(dataWrite),
		.halt(halt),
		.err(err)
	);

	// Both memories answer in the same cycle, word index from bits 8:1
	assign instr = imem[instrAddr[8:1]];
	assign dataRdData = dmem[dataAddr[8:1]];

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	function automatic logic [15:0] fillWord(int i);
		return 16'(i * 40503) ^ 16'h5a3c;
	endfunction

	// Data memory filled once in the first reset, then written by stores
	always @(posedge clk) begin
		if (reset && !dataInit) begin
			for (int i = 0; i < 256; i++) begin
				dmem[8'(i)] = fillWord(i);
			end
			dataInit = 1'b1;
		end else if (dataWrite) begin
			dmem[dataAddr[8:1]] = dataWrData;
		end
	end

	initial begin
		#(watchdogNs);
		$display("timeout: the core did not finish the programs in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic checkValue(string what, logic [15:0] expected, logic [15:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("mismatch %s %s: expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	// Rotate left, shift left, rotate right, shift right
	function automatic logic [15:0] shiftValue(logic [1:0] kind, logic [15:0] v, logic [3:0] a);
		int n;
		n = int'(a);
		case (kind)
			2'b00: return (v << n) | (v >> (16 - n));
			2'b01: return v << n;
			2'b10: return (v >> n) | (v << (16 - n));
			default: return v >> n;
		endcase
	endfunction

	function automatic logic [15:0] reverseBits(logic [15:0] v);
		logic [15:0] r;
		for (int i = 0; i < 16; i++) begin
			r[i] = v[15 - i];
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Instruction-set model, one instruction per call
	////////////////////////////////////////////////////////////////////////////
	task automatic stepModel();
		logic [15:0] ins, rsV, rtV, imm5s, imm5z, imm8s, imm8z, imm11s;
		logic [15:0] addr, wrVal, npc;
		logic [16:0] wide;
		logic [4:0] opc;
		logic [2:0] wrAddr;
		logic wrEn, expRead, expWrite, expErr, expHalt;
		ins = imem[mpc[8:1]];
		opc = ins[15:11];
		rsV = mregs[ins[10:8]];
		rtV = mregs[ins[7:5]];
		imm5s = {{11{ins[4]}}, ins[4:0]};
		imm5z = {11'b0, ins[4:0]};
		imm8s = {{8{ins[7]}}, ins[7:0]};
		imm8z = {8'b0, ins[7:0]};
		imm11s = {{5{ins[10]}}, ins[10:0]};
		addr = rsV + imm5s;
		wide = {1'b0, rsV} + {1'b0, rtV};
		npc = mpc + 16'd2;
		wrVal = 16'h0;
		wrAddr = ins[4:2];
		wrEn = 1'b0;
		expRead = 1'b0;
		expWrite = 1'b0;
		expErr = 1'b0;
		expHalt = 1'b0;
		if (opc[4:2] == 3'b111) begin
			// Compare group, Rs against Rt
			wrEn = 1'b1;
			case (opc[1:0])
				2'b00: wrVal = {15'b0, rsV == rtV};
				2'b01: wrVal = {15'b0, $signed(rsV) < $signed(rtV)};
				2'b10: wrVal = {15'b0, $signed(rsV) <= $signed(rtV)};
				default: wrVal = {15'b0, wide[16]};
			endcase
		end else begin
			case (opc)
				5'b11011: begin
					wrEn = 1'b1;
					case (ins[1:0])
						2'b00: wrVal = rsV + rtV;
						2'b01: wrVal = rtV - rsV;
						2'b10: wrVal = rsV ^ rtV;
						default: wrVal = rsV & ~rtV;
					endcase
				end
				5'b11010: begin
					wrEn = 1'b1;
					wrVal = shiftValue(ins[1:0], rsV, rtV[3:0]);
				end
				5'b11001: begin
					wrEn = 1'b1;
					wrVal = reverseBits(rsV);
				end
				5'b01000, 5'b01001, 5'b01010, 5'b01011: begin
					wrEn = 1'b1;
					wrAddr = ins[7:5];
					case (opc[1:0])
						2'b00: wrVal = imm5s - rsV;
						2'b01: wrVal = rsV + imm5s;
						2'b10: wrVal = rsV & ~imm5z;
						default: wrVal = rsV ^ imm5z;
					endcase
				end
				5'b10100, 5'b10101, 5'b10110, 5'b10111: begin
					wrEn = 1'b1;
					wrAddr = ins[7:5];
					wrVal = shiftValue(opc[1:0], rsV, ins[3:0]);
				end
				5'b10000: expWrite = 1'b1;
				5'b10001: begin
					expRead = 1'b1;
					wrEn = 1'b1;
					wrAddr = ins[7:5];
					wrVal = mdmem[addr[8:1]];
				end
				5'b10011: begin
					// Store, then the address goes to Rs
					expWrite = 1'b1;
					wrEn = 1'b1;
					wrAddr = ins[10:8];
					wrVal = addr;
				end
				5'b11000: begin
					wrEn = 1'b1;
					wrAddr = ins[10:8];
					wrVal = imm8s;
				end
				5'b10010: begin
					wrEn = 1'b1;
					wrAddr = ins[10:8];
					wrVal = (rsV << 8) | imm8z;
				end
				5'b01100: if (rsV != 16'h0) npc = mpc + 16'd2 + imm8s;
				5'b01101: if (rsV == 16'h0) npc = mpc + 16'd2 + imm8s;
				5'b01110: if (rsV[15]) npc = mpc + 16'd2 + imm8s;
				5'b01111: if (!rsV[15]) npc = mpc + 16'd2 + imm8s;
				5'b00100, 5'b00110: begin
					npc = mpc + 16'd2 + imm11s;
					wrEn = opc[1];
					wrAddr = 3'd7;
					wrVal = mpc + 16'd2;
				end
				5'b00101, 5'b00111: begin
					npc = rsV + imm8s;
					wrEn = opc[1];
					wrAddr = 3'd7;
					wrVal = mpc + 16'd2;
				end
				5'b00000: begin
					npc = mpc;
					expHalt = 1'b1;
				end
				5'b00010, 5'b00011: expErr = 1'b1;
				default: ;
			endcase
		end

		checkValue("instrAddr", mpc, instrAddr);
		checkValue("dataRead", {15'b0, expRead}, {15'b0, dataRead});
		checkValue("dataWrite", {15'b0, expWrite}, {15'b0, dataWrite});
		checkValue("err", {15'b0, expErr}, {15'b0, err});
		checkValue("halt", {15'b0, expHalt}, {15'b0, halt});
		if (expWrite) begin
			checkValue("dataAddr", addr, dataAddr);
			checkValue("dataWrData", rtV, dataWrData);
		end
		if (expRead) begin
			checkValue("dataAddr", addr, dataAddr);
		end

		if (expWrite) mdmem[addr[8:1]] = rtV;
		if (wrEn) mregs[wrAddr] = wrVal;
		mpc = npc;
		if (expHalt) haltSeen = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Program generation
	////////////////////////////////////////////////////////////////////////////
	task automatic put(logic [15:0] w);
		imem[8'(progIdx)] = w;
		progIdx++;
	endtask

	// Store of one register, so its value shows on dataWrData
	task automatic putStore(logic [2:0] src);
		logic [31:0] r;
		r = $random(seed);
		put({5'b10000, r[2:0], src, r[7:3]});
	endtask

	// Words skipped by a taken branch, only reached by falling through
	task automatic putFillers(int k);
		logic [31:0] r;
		for (int j = 0; j < k; j++) begin
			r = $random(seed);
			put({5'b11011, r[10:0]});
		end
	endtask

	// Control flow only lands on the first word of a group
	task automatic fillRandom();
		logic [31:0] r;
		logic [15:0] tgt;
		logic [2:0] dest;
		int kind, k;
		progIdx = 0;
		while (progIdx < randLen) begin
			r = $random(seed);
			kind = int'(r[3:0]) % 12;
			k = int'(r[5:4]);
			dest = r[8:6];
			if (progIdx + 7 > randLen) begin
				put(nopWord);
			end else begin
				case (kind)
					0: begin
						put({5'b11011, r[11:9], r[14:12], dest, r[16:15]});
						putStore(dest);
					end
					1: begin
						put({5'b11010, r[11:9], r[14:12], dest, r[16:15]});
						putStore(dest);
					end
					2: begin
						put({3'b111, r[10:9], r[13:11], r[16:14], dest, 2'b00});
						putStore(dest);
					end
					3: begin
						put({5'b11001, r[11:9], 3'b000, dest, 2'b00});
						putStore(dest);
					end
					4: begin
						put({r[9] ? {3'b101, r[11:10]} : {3'b010, r[11:10]},
							r[14:12], dest, r[19:15]});
						putStore(dest);
					end
					5: begin
						put({5'b11000, dest, r[16:9]});
						putStore(dest);
					end
					6: begin
						put({5'b10010, dest, r[16:9]});
						putStore(dest);
					end
					7: begin
						put({5'b10001, r[11:9], dest, r[16:12]});
						putStore(dest);
					end
					8: begin
						put({5'b10011, r[11:9], r[14:12], r[19:15]});
						putStore(r[11:9]);
					end
					9: begin
						put({3'b011, r[10:9], r[13:11], 5'b0, r[5:4], 1'b0});
						putFillers(k);
					end
					10: begin
						// J or JAL, the link shows through the store at the target
						put({3'b001, r[9], 1'b0, 8'b0, r[5:4], 1'b0});
						putFillers(k);
						putStore(3'd7);
					end
					default: begin
						// JR or JALR through an absolute target built in r6
						tgt = 16'((progIdx + 3 + k) * 2);
						put({5'b11000, 3'd6, tgt[15:8]});
						put({5'b10010, 3'd6, tgt[7:0]});
						put({3'b001, r[9], 1'b1, 3'd6, 8'h00});
						putFillers(k);
						putStore(3'd7);
					end
				endcase
			end
		end
		for (int i = randLen; i < 256; i++) begin
			imem[8'(i)] = haltWord;
		end
	endtask

	// SIIC and RTI between loads of known values
	task automatic fillDirected();
		for (int i = 0; i < 256; i++) begin
			imem[8'(i)] = haltWord;
		end
		imem[0] = {5'b11000, 3'd1, 8'h05};
		imem[1] = {5'b11000, 3'd2, 8'h33};
		imem[2] = {5'b00010, 3'd1, 8'hff};
		imem[3] = nopWord;
		imem[4] = {5'b00011, 3'd2, 8'h0f};
		imem[5] = {5'b10000, 3'd0, 3'd1, 5'd0};
		imem[6] = {5'b10000, 3'd0, 3'd2, 5'd2};
		imem[7] = {5'b00010, 11'h000};
		imem[8] = haltWord;
	endtask

	task automatic runProgram(string name);
		int startErrors, cycles, postHalt;
		testName = name;
		startErrors = errorCount;
		@(posedge clk);
		#5 reset = 1'b1;
		repeat (4) begin
			@(negedge clk);
			checkCount++;
			if (dataRead || dataWrite || err || halt) begin
				errorCount++;
				$display("%s: an output strobe was high during reset", name);
			end
			@(posedge clk);
		end
		#5 reset = 1'b0;
		mpc = 16'h0000;
		for (int i = 0; i < 8; i++) begin
			mregs[3'(i)] = 16'h0;
		end
		haltSeen = 1'b0;
		cycles = 0;
		postHalt = 0;
		// Run to HALT, then two more cycles with the PC frozen
		while (postHalt < 3 && cycles < 300) begin
			@(negedge clk);
			stepModel();
			cycles++;
			if (haltSeen) postHalt++;
		end
		if (postHalt < 3) begin
			errorCount++;
			$display("%s: the program never reached HALT", name);
		end
		$display("test %s: %0d cycles, %0d errors", name, cycles, errorCount - startErrors);
	endtask

	initial begin
		reset = 1'b1;
		seed = 32'hdb730b56;
		errorCount = 0;
		checkCount = 0;
		progIdx = 0;
		mpc = 16'h0000;
		haltSeen = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mdmem[8'(i)] = fillWord(i);
		end
		fillRandom();
		runProgram("random");
		fillDirected();
		runProgram("illegal");
		$display("checks %0d, errors %0d, assertion failures %0d",
			checkCount, errorCount, dut_i.checker_i.failCount);
		if (errorCount == 0 && dut_i.checker_i.failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/cpuCore_checker.sv
////////////////////////////////////////////////////////////////////////////
// Port protocol assertions for the WISC core
// Memory strobes exclusive and quiet in reset, err one cycle,
// halt held until reset, bound into every cpuCore instance
// Failure count read by the testbench at the end of the run
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cpuCore_checker (
	input wire logic clk,
	input wire logic reset,
	input wire logic dataRead,
	input wire logic dataWrite,
	input wire logic err,
	input wire logic halt
);

	// Number of failed assertions so far
	int failCount = 0;

	// One memory access per instruction
	strobeExclusive: assert property (@(posedge clk) !(dataRead && dataWrite))
		else begin
			failCount++;
			$error("dataRead and dataWrite high together");
		end

	// Nothing commits in reset
	resetQuiet: assert property (@(posedge clk) reset |-> !dataRead && !dataWrite)
		else begin
			failCount++;
			$error("memory strobe high during reset");
		end

	// Illegal opcode flag is a strobe
	errSingle: assert property (@(posedge clk) err |=> !err)
		else begin
			failCount++;
			$error("err held longer than one cycle");
		end

	// Halt is sticky
	haltHeld: assert property (@(posedge clk) halt |=> halt || reset)
		else begin
			failCount++;
			$error("halt dropped before reset");
		end

endmodule

bind cpuCore cpuCore_checker checker_i (
	.clk(clk),
	.reset(reset),
	.dataRead(dataRead),
	.dataWrite(dataWrite),
	.err(err),
	.halt(halt)
);

`default_nettype wire

//--- hdl/control.sv
////////////////////////////////////////////////////////////////////////////
// Main decoder of the WISC core
// Combinational map from opcode and funct to every datapath control,
// the halt level and the illegal-opcode flag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module control (
	input  wire isaPkg::opcode        opcode,
	input  wire logic [1:0]           funct,
	output logic                      regWrite,
	output logic                      dataWrite,
	output logic                      dataRead,
	output logic                      memToReg,
	output logic                      aluSrcReg,
	output logic                      invA,
	output logic                      invB,
	output logic                      cin,
	output logic                      linkWrite,
	output logic                      halt,
	output controlPkg::regDst         dst,
	output controlPkg::extSel         ext,
	output controlPkg::aluOp          aluOperation,
	output controlPkg::branchCond     branch,
	output logic                      jumpReg,
	output logic                      err
);

	import isaPkg::*;
	import controlPkg::*;

	always_comb begin
		// Most instructions write a register through the ALU
		regWrite = 1'b1;
		memToReg = 1'b0;
		linkWrite = 1'b0;
		dst = dstRd;
		// Second operand from Rt unless an immediate form overrides
		aluSrcReg = 1'b1;
		ext = sign5;
		aluOperation = opAdd;
		invA = 1'b0;
		invB = 1'b0;
		cin = 1'b0;
		// No memory access, no redirect
		dataWrite = 1'b0;
		dataRead = 1'b0;
		branch = brNever;
		jumpReg = 1'b0;
		halt = 1'b0;
		err = 1'b0;

		if (opcode[4:2] == cmpPrefix) begin
			// Compares work on Rs minus Rt
			invB = 1'b1;
			cin = 1'b1;
			case (opcode[1:0])
				2'b00: aluOperation = opSeq;
				2'b01: aluOperation = opSlt;
				2'b10: aluOperation = opSle;
				default: begin
					// SCO wants the carry of the plain sum
					aluOperation = opSco;
					invB = 1'b0;
					cin = 1'b0;
				end
			endcase
		end else begin
			case (opcode)
				////////////////////////////////////////////////////////////////////////////
				// R-format
				////////////////////////////////////////////////////////////////////////////
				opcAluGrp1: begin
					unique case (funct1'(funct))
						f1Add: aluOperation = opAdd;
						f1Sub: begin
							// Rt minus Rs
							invA = 1'b1;
							cin = 1'b1;
						end
						f1Xor: aluOperation = opXor;
						f1Andn: begin
							aluOperation = opAndn;
							invB = 1'b1;
						end
					endcase
				end
				opcAluGrp2: begin
					unique case (funct2'(funct))
						f2Rol: aluOperation = opRol;
						f2Sll: aluOperation = opSll;
						f2Ror: aluOperation = opRor;
						f2Srl: aluOperation = opSrl;
					endcase
				end
				opcBtr: aluOperation = opBtr;

				////////////////////////////////////////////////////////////////////////////
				// I-format 1, destination in bits 7:5
				////////////////////////////////////////////////////////////////////////////
				opcAddi, opcSubi: begin
					dst = dstRdI;
					aluSrcReg = 1'b0;
					// Immediate minus Rs for SUBI
					invA = (opcode == opcSubi);
					cin = (opcode == opcSubi);
				end
				opcAndni, opcXori: begin
					dst = dstRdI;
					aluSrcReg = 1'b0;
					ext = zero5;
					aluOperation = (opcode == opcXori) ? opXor : opAndn;
					invB = (opcode == opcAndni);
				end
				opcRoli, opcSlli, opcRori, opcSrli: begin
					dst = dstRdI;
					aluSrcReg = 1'b0;
					ext = zero5;
					// Low opcode bits follow the shift funct encoding
					unique case (funct2'(opcode[1:0]))
						f2Rol: aluOperation = opRol;
						f2Sll: aluOperation = opSll;
						f2Ror: aluOperation = opRor;
						f2Srl: aluOperation = opSrl;
					endcase
				end
				opcSt: begin
					regWrite = 1'b0;
					aluSrcReg = 1'b0;
					dataWrite = 1'b1;
				end
				opcLd: begin
					dst = dstRdI;
					aluSrcReg = 1'b0;
					dataRead = 1'b1;
					memToReg = 1'b1;
				end
				opcStu: begin
					// Effective address goes back to Rs
					dst = dstRs;
					aluSrcReg = 1'b0;
					dataWrite = 1'b1;
				end

				////////////////////////////////////////////////////////////////////////////
				// I-format 2 and jumps
				////////////////////////////////////////////////////////////////////////////
				opcBeqz, opcBnez, opcBltz, opcBgez: begin
					regWrite = 1'b0;
					ext = sign8;
					unique case (opcode)
						opcBeqz: branch = brIfZero;
						opcBnez: branch = brIfNonZero;
						opcBltz: branch = brIfNegative;
						default: branch = brIfNonNegative;
					endcase
				end
				opcLbi: begin
					dst = dstRs;
					aluSrcReg = 1'b0;
					ext = sign8;
					aluOperation = opPassB;
				end
				opcSlbi: begin
					dst = dstRs;
					aluSrcReg = 1'b0;
					ext = zero8;
					aluOperation = opSlbi;
				end
				opcJ, opcJal: begin
					// PC-relative, link only for JAL
					regWrite = (opcode == opcJal);
					linkWrite = 1'b1;
					dst = dstR7;
					ext = sign11;
					branch = brAlways;
				end
				opcJr, opcJalr: begin
					// Target is Rs plus immediate out of the ALU
					regWrite = (opcode == opcJalr);
					linkWrite = 1'b1;
					dst = dstR7;
					aluSrcReg = 1'b0;
					ext = sign8;
					branch = brAlways;
					jumpReg = 1'b1;
				end

				////////////////////////////////////////////////////////////////////////////
				// Special
				////////////////////////////////////////////////////////////////////////////
				opcNop: regWrite = 1'b0;
				opcHalt: begin
					regWrite = 1'b0;
					halt = 1'b1;
				end
				// No exception support, siic and RTI flag like unknown opcodes
				opcSiic, opcRti: begin
					regWrite = 1'b0;
					err = 1'b1;
				end
				default: begin
					regWrite = 1'b0;
					err = 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/controlPkg.sv
////////////////////////////////////////////////////////////////////////////
// Decoded control vocabulary of the WISC core
// ALU operation, destination select, immediate extension select
// and branch condition enums
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package controlPkg;

	// Operations of the execute unit
	typedef enum logic [3:0] {
		opAdd, opXor, opAndn,
		opRol, opSll, opRor, opSrl,
		opSeq, opSlt, opSle, opSco,
		opBtr, opPassB, opSlbi
	} aluOp;

	// Write-back register select
	// dstRd bits 4:2, dstRdI bits 7:5, dstRs bits 10:8
	typedef enum logic [1:0] {dstRd, dstRdI, dstRs, dstR7} regDst;

	// Immediate width and extension kind
	typedef enum logic [2:0] {zero5, sign5, zero8, sign8, sign11} extSel;

	// Branch condition, always tested against Rs
	typedef enum logic [2:0] {
		brNever,
		brAlways,
		brIfZero,
		brIfNonZero,
		brIfNegative,
		brIfNonNegative
	} branchCond;

endpackage

`default_nettype wire

//--- hdl/cpuCore.sv
////////////////////////////////////////////////////////////////////////////
// Single-cycle WISC core
// Program counter, decoder, register file, execute unit,
// immediate extension, branch resolution, memory ports and write-back
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module cpuCore #(
	parameter logic [isaPkg::dataWidth-1:0] resetPc = '0
) (
	input  wire logic                          clk,
	input  wire logic                          reset,
	output logic [isaPkg::dataWidth-1:0]       instrAddr,
	input  wire logic [isaPkg::dataWidth-1:0]  instr,
	output logic [isaPkg::dataWidth-1:0]       dataAddr,
	output logic [isaPkg::dataWidth-1:0]       dataWrData,
	input  wire logic [isaPkg::dataWidth-1:0]  dataRdData,
	output logic                               dataRead,
	output logic                               dataWrite,
	output logic                               halt,
	output logic                               err
);

	import isaPkg::*;
	import controlPkg::*;

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] pcPlus2;
	logic [dataWidth-1:0] nextPc;
	logic [dataWidth-1:0] immExt;
	logic [dataWidth-1:0] branchTarget;
	logic [dataWidth-1:0] readDataA;
	logic [dataWidth-1:0] readDataB;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] writeData;
	logic [regAddrWidth-1:0] writeAddr;
	logic taken;

	// Decoded controls
	opcode opField;
	logic regWrite, dataWriteInstr, dataReadInstr, memToReg, aluSrcReg;
	logic invA, invB, cin, linkWrite, haltInstr, jumpReg, errInstr;
	regDst dst;
	extSel ext;
	aluOp aluOperation;
	branchCond branch;

	assign opField = opcode'(instr[opMsb:opLsb]);

	control control_i (
		.opcode(opField),
		.funct(instr[1:0]),
		.regWrite(regWrite),
		.dataWrite(dataWriteInstr),
		.dataRead(dataReadInstr),
		.memToReg(memToReg),
		.aluSrcReg(aluSrcReg),
		.invA(invA),
		.invB(invB),
		.cin(cin),
		.linkWrite(linkWrite),
		.halt(haltInstr),
		.dst(dst),
		.ext(ext),
		.aluOperation(aluOperation),
		.branch(branch),
		.jumpReg(jumpReg),
		.err(errInstr)
	);

	// Port B reads bits 7:5, Rt of R-format and store data of ST and STU
	regFile regFile_i (
		.clk(clk),
		.reset(reset),
		.readAddrA(instr[rsMsb:rsLsb]),
		.readAddrB(instr[rtMsb:rtLsb]),
		.writeAddr(writeAddr),
		.writeEn(regWrite),
		.writeData(writeData),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	// Immediate extension
	always_comb begin
		unique case (ext)
			zero5:   immExt = {11'b0, instr[4:0]};
			sign5:   immExt = {{11{instr[4]}}, instr[4:0]};
			zero8:   immExt = {8'b0, instr[7:0]};
			sign8:   immExt = {{8{instr[7]}}, instr[7:0]};
			sign11:  immExt = {{5{instr[10]}}, instr[10:0]};
			default: immExt = '0;
		endcase
	end

	assign aluB = aluSrcReg ? readDataB : immExt;

	execute execute_i (
		.a(readDataA),
		.b(aluB),
		.invA(invA),
		.invB(invB),
		.cin(cin),
		.aluOperation(aluOperation),
		.result(aluResult)
	);

	////////////////////////////////////////////////////////////////////////////
	// Write-back
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		unique case (dst)
			dstRd:   writeAddr = instr[rdMsb:rdLsb];
			dstRdI:  writeAddr = instr[rtMsb:rtLsb];
			dstRs:   writeAddr = instr[rsMsb:rsLsb];
			default: writeAddr = regAddrWidth'(regCount - 1);
		endcase
	end

	// Link value, load data or ALU
	assign writeData = linkWrite ? pcPlus2 : (memToReg ? dataRdData : aluResult);

	////////////////////////////////////////////////////////////////////////////
	// Next PC
	////////////////////////////////////////////////////////////////////////////
	assign pcPlus2 = pc + 16'd2;
	assign branchTarget = pcPlus2 + immExt;

	// Conditions test Rs
	always_comb begin
		unique case (branch)
			brNever:         taken = 1'b0;
			brAlways:        taken = 1'b1;
			brIfZero:        taken = (readDataA == '0);
			brIfNonZero:     taken = (readDataA != '0);
			brIfNegative:    taken = readDataA[dataWidth-1];
			brIfNonNegative: taken = !readDataA[dataWidth-1];
			default:         taken = 1'b0;
		endcase
	end

	// HALT holds the PC, so HALT keeps being fetched
	always_comb begin
		if (haltInstr) begin
			nextPc = pc;
		end else if (taken) begin
			nextPc = jumpReg ? aluResult : branchTarget;
		end else begin
			nextPc = pcPlus2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
		end else begin
			pc <= nextPc;
		end
	end

	assign instrAddr = pc;

	// Memory port, address from the ALU
	assign dataAddr = aluResult;
	assign dataWrData = readDataB;

	// Nothing commits while reset is high
	assign dataRead = dataReadInstr & ~reset;
	assign dataWrite = dataWriteInstr & ~reset;
	assign halt = haltInstr & ~reset;
	assign err = errInstr & ~reset;

endmodule

`default_nettype wire

//--- hdl/execute.sv
////////////////////////////////////////////////////////////////////////////
// Execute unit of the WISC core
// Adder with operand inversion and carry-in, logic ops, shifts and
// rotates, compares, bit reversal and the byte-load results
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module execute (
	input  wire logic [isaPkg::dataWidth-1:0]  a,
	input  wire logic [isaPkg::dataWidth-1:0]  b,
	input  wire logic                          invA,
	input  wire logic                          invB,
	input  wire logic                          cin,
	input  wire controlPkg::aluOp              aluOperation,
	output logic [isaPkg::dataWidth-1:0]       result
);

	import isaPkg::*;
	import controlPkg::*;

	localparam int msb = dataWidth - 1;

	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth:0] sum;
	logic zero;
	logic overflow;
	logic less;
	logic [3:0] shamt;
	logic [2*dataWidth-1:0] rolWide;
	logic [2*dataWidth-1:0] rorWide;
	logic [dataWidth-1:0] reversed;

	// Shared adder
	always_comb begin
		opA = invA ? ~a : a;
		opB = invB ? ~b : b;
		sum = {1'b0, opA} + {1'b0, opB} + {{dataWidth{1'b0}}, cin};
	end

	// Compare flags from Rs minus Rt
	assign zero = (sum[msb:0] == '0);
	// Signed overflow of a subtraction
	assign overflow = (a[msb] != b[msb]) && (sum[msb] != a[msb]);
	assign less = sum[msb] ^ overflow;

	// Shift amount from the low four bits
	assign shamt = b[3:0];
	// Rotates through a doubled word
	assign rolWide = {a, a} << shamt;
	assign rorWide = {a, a} >> shamt;

	// BTR mirror
	always_comb begin
		for (int i = 0; i < dataWidth; i++) begin
			reversed[i] = a[msb-i];
		end
	end

	always_comb begin
		unique case (aluOperation)
			opAdd:   result = sum[msb:0];
			opXor:   result = opA ^ opB;
			// opB is already inverted for ANDN
			opAndn:  result = opA & opB;
			opRol:   result = rolWide[2*dataWidth-1:dataWidth];
			opSll:   result = a << shamt;
			opRor:   result = rorWide[msb:0];
			opSrl:   result = a >> shamt;
			opSeq:   result = {{msb{1'b0}}, zero};
			opSlt:   result = {{msb{1'b0}}, less};
			opSle:   result = {{msb{1'b0}}, less | zero};
			// Carry out of the uninverted sum
			opSco:   result = {{msb{1'b0}}, sum[dataWidth]};
			opBtr:   result = reversed;
			// LBI result is the extended immediate
			opPassB: result = b;
			opSlbi:  result = (a << 8) | b;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/isaPkg.sv
////////////////////////////////////////////////////////////////////////////
// WISC instruction-set encodings
// Word width, register count and instruction field positions
// Primary opcode enum, compare-group prefix and the two funct enums
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package isaPkg;

	// Architectural sizes
	localparam int dataWidth = 16;
	localparam int regCount = 8;
	localparam int regAddrWidth = $clog2(regCount);

	// Instruction field positions
	localparam int opMsb = 15;
	localparam int opLsb = 11;
	localparam int rsMsb = 10;
	localparam int rsLsb = 8;
	// Rt of R-format, Rd of I-format 1
	localparam int rtMsb = 7;
	localparam int rtLsb = 5;
	// Rd of R-format
	localparam int rdMsb = 4;
	localparam int rdLsb = 2;

	// Primary opcodes in bits 15:11
	typedef enum logic [4:0] {
		opcHalt    = 5'b00000,
		opcNop     = 5'b00001,
		opcSiic    = 5'b00010,
		opcRti     = 5'b00011,
		opcJ       = 5'b00100,
		opcJr      = 5'b00101,
		opcJal     = 5'b00110,
		opcJalr    = 5'b00111,
		opcSubi    = 5'b01000,
		opcAddi    = 5'b01001,
		opcAndni   = 5'b01010,
		opcXori    = 5'b01011,
		opcBnez    = 5'b01100,
		opcBeqz    = 5'b01101,
		opcBltz    = 5'b01110,
		opcBgez    = 5'b01111,
		opcSt      = 5'b10000,
		opcLd      = 5'b10001,
		opcSlbi    = 5'b10010,
		opcStu     = 5'b10011,
		opcRoli    = 5'b10100,
		opcSlli    = 5'b10101,
		opcRori    = 5'b10110,
		opcSrli    = 5'b10111,
		opcLbi     = 5'b11000,
		opcBtr     = 5'b11001,
		opcAluGrp2 = 5'b11010,
		opcAluGrp1 = 5'b11011
	} opcode;

	// Compare group 111xx
	// Low two opcode bits pick seq, slt, sle or sco
	localparam logic [2:0] cmpPrefix = 3'b111;

	// Funct of the add and logic group
	typedef enum logic [1:0] {f1Add, f1Sub, f1Xor, f1Andn} funct1;

	// Funct of the shift and rotate group, also the low opcode bits of the immediates
	typedef enum logic [1:0] {f2Rol, f2Sll, f2Ror, f2Srl} funct2;

endpackage

`default_nettype wire

//--- hdl/regFile.sv
////////////////////////////////////////////////////////////////////////////
// Architectural register file
// Eight 16-bit registers, two combinational read ports, one write port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input  wire logic                              clk,
	input  wire logic                              reset,
	input  wire logic [isaPkg::regAddrWidth-1:0]   readAddrA,
	input  wire logic [isaPkg::regAddrWidth-1:0]   readAddrB,
	input  wire logic [isaPkg::regAddrWidth-1:0]   writeAddr,
	input  wire logic                              writeEn,
	input  wire logic [isaPkg::dataWidth-1:0]      writeData,
	output logic [isaPkg::dataWidth-1:0]           readDataA,
	output logic [isaPkg::dataWidth-1:0]           readDataB
);

	import isaPkg::*;

	logic [dataWidth-1:0] regs [regCount];

	// Write at the edge, all registers cleared while reset is high
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Reads see the old value in a write cycle
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

//--- list.f
hdl/isaPkg.sv
hdl/controlPkg.sv
hdl/control.sv
hdl/regFile.sv
hdl/execute.sv
hdl/cpuCore.sv
bench/cpuCore_checker.sv
bench/cpuCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the WISC core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module cpuCoreTb \
	-f list.f \
	-o cpuCoreSim

./obj_dir/cpuCoreSim > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
	exit 1
fi
exit 0
